//--- Bender.yml
package:
  name: synapse_core

sources:
  - synapse_pkg.sv
  - syn_fetch.sv
  - syn_decoder.sv
  - syn_alu.sv
  - syn_source_mux.sv
  - synapse_core.sv
  - target: test
    files:
      - synapse_core_checker.sv
      - tb_synapse_core.sv

//--- list.f
synapse_pkg.sv
syn_fetch.sv
syn_decoder.sv
syn_alu.sv
syn_source_mux.sv
synapse_core.sv
synapse_core_checker.sv
tb_synapse_core.sv

//--- syn_alu.sv
`timescale 1ns/1ps

module syn_alu import synapse_pkg::*; (
    input  logic              sysreset,
    input  logic              sysclk,
    input  logic [word_w-1:0] r0,
    input  logic [word_w-1:0] r1,
    input  logic [word_w-1:0] r2,
    input  logic [word_w-1:0] r3,
    input  logic              op_setf,
    input  logic              op_clrf,
    input  logic              copy_bit0,
    output logic [word_w-1:0] ad0,
    output logic [word_w-1:0] ad1,
    output logic [word_w-1:0] and0,
    output logic [word_w-1:0] or0,
    output logic [word_w-1:0] xor0,
    output logic [word_w-1:0] flags
);

    logic            cin_flag;
    logic            cout_flag;
    logic [word_w:0] ad0_sum;
    logic            eq;
    logic            gt;

    // ad0 adds r0 and r1 with the carry-in flag.
    assign ad0_sum = {1'b0, r0} + {1'b0, r1} + {{word_w{1'b0}}, cin_flag};

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            cin_flag  <= 1'b0;
            cout_flag <= 1'b0;
        end else begin
            // setf and clrf act only when bit 0 of the copied word is set.
            if (op_setf) begin
                cin_flag <= cin_flag || copy_bit0;
            end
            if (op_clrf) begin
                cin_flag <= cin_flag && !copy_bit0;
            end
            cout_flag <= ad0_sum[word_w];
        end
    end

    // result registers follow their operands one cycle later.
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            ad0  <= '0;
            ad1  <= '0;
            and0 <= '0;
            or0  <= '0;
            xor0 <= '0;
        end else begin
            ad0  <= ad0_sum[word_w-1:0];
            ad1  <= r2 + r3;
            and0 <= r0 & r1;
            or0  <= r0 | r1;
            xor0 <= r0 ^ r1;
        end
    end

    // comparator on the live r0 and r1.
    assign eq = (r0 == r1);
    assign gt = (r0 > r1);

    always_comb begin
        // unused upper bits read as 1.
        flags = '1;
        flags[flag_z0]        = ~|r0;
        flags[flag_z2]        = ~|r2;
        flags[flag_z4]        = 1'b0;
        flags[flag_and0_zero] = ~|(r0 & r1);
        flags[flag_carry]     = cout_flag;
        flags[flag_lt]        = !(eq || gt);
        flags[flag_gt]        = gt;
        flags[flag_eq]        = eq;
    end

endmodule

//--- syn_decoder.sv
`timescale 1ns/1ps

module syn_decoder import synapse_pkg::*; #(
    parameter int num_regs = 8
) (
    input  instr_u              exr,
    input  logic                enable_exec,
    output logic                op_clrf,
    output logic                op_setf,
    output logic                op_br,
    output logic                op_bn,
    output logic                op_ret_load,
    output logic                op_return,
    output logic                op_imm16,
    output logic [num_regs-1:0] r_load,
    output logic [num_regs-1:0] r_read
);

    logic [dest_w-1:0] dest;
    logic [src_w-1:0]  src;

    assign dest = exr.op.dest;
    assign src  = exr.op.src;

    // control operators.
    // every strobe is dead while the slot is skipped or stalled.
    assign op_clrf     = enable_exec && (dest == dest_clrf);
    assign op_setf     = enable_exec && (dest == dest_setf);
    assign op_br       = enable_exec && (dest == dest_br);
    assign op_bn       = enable_exec && (dest == dest_bn);
    assign op_ret_load = enable_exec && (dest == dest_ret_addr);
    assign op_return   = enable_exec && (dest == dest_return);

    // inline constant source.
    assign op_imm16 = enable_exec && (src == src_imm16);

    // register file strobes, one bit per register.
    // destinations between num_regs and 0x2f drive nothing.
    for (genvar i = 0; i < num_regs; i++) begin : g_reg
        assign r_load[i] = enable_exec && (dest == dest_w'(i));
        assign r_read[i] = enable_exec && (src == src_w'(i));
    end

endmodule

//--- syn_fetch.sv
`timescale 1ns/1ps

module syn_fetch import synapse_pkg::*; #(
    parameter int ipr_w = 10
) (
    input  logic              sysreset,
    input  logic              sysclk,
    input  instr_u            code_in,
    input  logic              code_ready,
    input  logic              op_br,
    input  logic              op_bn,
    input  logic              op_return,
    input  logic              op_ret_load,
    input  logic              op_imm16,
    input  logic [word_w-1:0] copy_data,
    input  logic [word_w-1:0] flags,
    output logic [ipr_w-1:0]  code_addr,
    output instr_u            exr,
    output logic              enable_exec,
    output logic [ipr_w-1:0]  return_addr
);

    // instruction pointer, two words ahead of exr.
    logic [ipr_w-1:0] ipr;
    // low until the first clock edge after reset.
    logic             run;
    // set until the reset word in exr has executed.
    logic             boot;
    // exr holds an inline constant.
    logic             skip_const;
    // dead slots left after a branch, return or boot.
    logic [1:0]       skip_jump;
    logic             advance;
    logic             selected_flag;
    logic             branch_taken;
    logic             jump;

    // the pipeline moves only while the code memory is ready.
    assign advance = code_ready && run;
    assign enable_exec = advance && !skip_const && (skip_jump == 2'd0);

    // the low four source bits pick the tested flag.
    assign selected_flag = flags[exr.op.src[3:0]];
    assign branch_taken = (op_br && selected_flag) || (op_bn && !selected_flag);
    // a jump refills the pipeline from a new address.
    assign jump = branch_taken || op_return;

    assign code_addr = ipr;

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            ipr         <= '0;
            exr         <= '0;
            return_addr <= '0;
            boot        <= 1'b1;
            skip_const  <= 1'b0;
            skip_jump   <= 2'd0;
        end else if (advance) begin
            exr  <= code_in;
            boot <= 1'b0;

            // branch target is the word after the branch.
            if (branch_taken) begin
                ipr <= code_in.data[ipr_w-1:0];
            end else if (op_return) begin
                ipr <= return_addr;
            end else begin
                ipr <= ipr + ipr_w'(1);
            end

            // return saves the address after its own dead slot.
            if (op_return) begin
                return_addr <= ipr;
            end else if (op_ret_load) begin
                return_addr <= copy_data[ipr_w-1:0];
            end

            // the constant word arrives in exr on the next edge.
            skip_const <= op_imm16;

            // a jump leaves two stale words, a branch not taken leaves one.
            // the reset word also leaves one, since code_in repeats address 0.
            if (jump) begin
                skip_jump <= 2'd2;
            end else if (op_br || op_bn || boot) begin
                skip_jump <= 2'd1;
            end else if (skip_jump != 2'd0) begin
                skip_jump <= skip_jump - 2'd1;
            end
        end
    end

endmodule

//--- syn_source_mux.sv
`timescale 1ns/1ps

module syn_source_mux import synapse_pkg::*; #(
    parameter int num_regs = 8
) (
    input  logic [src_w-1:0]               src,
    input  logic [num_regs-1:0][word_w-1:0] r,
    input  logic [word_w-1:0]              return_addr,
    input  instr_u                         code_in,
    input  logic [word_w-1:0]              ad0,
    input  logic [word_w-1:0]              ad1,
    input  logic [word_w-1:0]              and0,
    input  logic [word_w-1:0]              or0,
    input  logic [word_w-1:0]              xor0,
    output logic [word_w-1:0]              copy_data
);

    // shifter operand.
    logic [word_w-1:0] sh_in;

    assign sh_in = r[0];

    always_comb begin
        // any unmapped code reads zero.
        copy_data = '0;

        // 0x200 to 0x2ff carry an 8-bit constant in the source field.
        if (src[src_w-1 -: 2] == src_small_const_hi) begin
            copy_data = {{(word_w-8){1'b0}}, src[7:0]};
        end else begin
            case (src)
                src_ret_addr: copy_data = return_addr;
                src_ad0:      copy_data = ad0;
                src_ad1:      copy_data = ad1;
                src_and0:     copy_data = and0;
                src_or0:      copy_data = or0;
                src_xor0:     copy_data = xor0;
                // shifts of r0 fill with zeros.
                src_sh1r:     copy_data = {1'b0, sh_in[word_w-1:1]};
                src_sh1l:     copy_data = {sh_in[word_w-2:0], 1'b0};
                src_sh4l:     copy_data = {sh_in[word_w-5:0], 4'h0};
                src_sh4r:     copy_data = {4'h0, sh_in[word_w-1:4]};
                src_neg1:     copy_data = '1;
                // the word after the move, still in code_in.
                src_imm16:    copy_data = code_in.data;
                default:      copy_data = '0;
            endcase
        end

        // register file occupies the lowest source codes.
        for (int i = 0; i < num_regs; i++) begin
            if (src == src_w'(i)) begin
                copy_data = r[i];
            end
        end
    end

endmodule

//--- synapse_core.sv
`timescale 1ns/1ps

module synapse_core import synapse_pkg::*; #(
    parameter int num_regs = 8,
    parameter int ipr_w    = 10
) (
    input  logic                           sysreset,
    input  logic                           sysclk,
    input  instr_u                         code_in,
    input  logic                           code_ready,
    input  logic [num_regs-1:0][word_w-1:0] r,
    output logic [ipr_w-1:0]               code_addr,
    output logic [num_regs-1:0]            r_load,
    output logic [num_regs-1:0]            r_read,
    output logic [word_w-1:0]              r_load_data
);

    instr_u            code_in_pass;
    instr_u            exr;
    logic              enable_exec;
    logic [ipr_w-1:0]  return_addr;
    logic [word_w-1:0] return_addr_word;
    logic              op_clrf;
    logic              op_setf;
    logic              op_br;
    logic              op_bn;
    logic              op_ret_load;
    logic              op_return;
    logic              op_imm16;
    logic [word_w-1:0] copy_data;
    logic [word_w-1:0] ad0;
    logic [word_w-1:0] ad1;
    logic [word_w-1:0] and0;
    logic [word_w-1:0] or0;
    logic [word_w-1:0] xor0;
    logic [word_w-1:0] flags;
    // alu operands r0 to r3, zero where the register file is smaller.
    logic [3:0][word_w-1:0] r_op;

    // code_in feeds both the fetch unit and the imm16 source.
    assign code_in_pass = code_in;
    assign return_addr_word = {{(word_w-ipr_w){1'b0}}, return_addr};
    assign r_load_data = copy_data;

    for (genvar i = 0; i < 4; i++) begin : g_operand
        if (i < num_regs) begin : g_present
            assign r_op[i] = r[i];
        end else begin : g_absent
            assign r_op[i] = '0;
        end
    end

    syn_fetch #(
        .ipr_w(ipr_w)
    ) u_fetch (
        .sysreset(sysreset),
        .sysclk(sysclk),
        .code_in(code_in_pass),
        .code_ready(code_ready),
        .op_br(op_br),
        .op_bn(op_bn),
        .op_return(op_return),
        .op_ret_load(op_ret_load),
        .op_imm16(op_imm16),
        .copy_data(copy_data),
        .flags(flags),
        .code_addr(code_addr),
        .exr(exr),
        .enable_exec(enable_exec),
        .return_addr(return_addr)
    );

    syn_decoder #(
        .num_regs(num_regs)
    ) u_decoder (
        .exr(exr),
        .enable_exec(enable_exec),
        .op_clrf(op_clrf),
        .op_setf(op_setf),
        .op_br(op_br),
        .op_bn(op_bn),
        .op_ret_load(op_ret_load),
        .op_return(op_return),
        .op_imm16(op_imm16),
        .r_load(r_load),
        .r_read(r_read)
    );

    syn_alu u_alu (
        .sysreset(sysreset),
        .sysclk(sysclk),
        .r0(r_op[0]),
        .r1(r_op[1]),
        .r2(r_op[2]),
        .r3(r_op[3]),
        .op_setf(op_setf),
        .op_clrf(op_clrf),
        .copy_bit0(copy_data[0]),
        .ad0(ad0),
        .ad1(ad1),
        .and0(and0),
        .or0(or0),
        .xor0(xor0),
        .flags(flags)
    );

    syn_source_mux #(
        .num_regs(num_regs)
    ) u_source_mux (
        .src(exr.op.src),
        .r(r),
        .return_addr(return_addr_word),
        .code_in(code_in_pass),
        .ad0(ad0),
        .ad1(ad1),
        .and0(and0),
        .or0(or0),
        .xor0(xor0),
        .copy_data(copy_data)
    );

endmodule

//--- synapse_core_checker.sv
`timescale 1ns/1ps

module synapse_core_checker #(
    parameter int num_regs = 8,
    parameter int ipr_w    = 10
) (
    input logic                sysreset,
    input logic                sysclk,
    input logic                code_ready,
    input logic [ipr_w-1:0]    code_addr,
    input logic [num_regs-1:0] r_load,
    input logic [num_regs-1:0] r_read
);

    // one register written and one read at most.
    a_onehot: assert property (@(posedge sysreset) disable iff (sysclk)
        $onehot0(r_load) && $onehot0(r_read))
        else $error("more than one register strobe set");

    // a stalled cycle executes nothing.
    a_stall_load: assert property (@(posedge sysreset) disable iff (sysclk)
        !code_ready |-> (r_load == '0))
        else $error("register load during a stall");

    // fetch address holds across a stall.
    a_stall_addr: assert property (@(posedge sysreset) disable iff (sysclk)
        !code_ready |=> $stable(code_addr))
        else $error("code address moved after a stall");

    a_reset_load: assert property (@(posedge sysreset)
        sysclk |-> (r_load == '0))
        else $error("register load during reset");

endmodule

//--- synapse_pkg.sv
package synapse_pkg;

    // data word and instruction word width.
    localparam int word_w = 16;
    // destination field, the upper part of a move.
    localparam int dest_w = 6;
    // source field, the lower part of a move.
    localparam int src_w = 10;

    // the executing word is read as a move or as raw data.
    // raw data is an inline constant or a branch target.
    typedef union packed {
        struct packed {
            logic [dest_w-1:0] dest;
            logic [src_w-1:0]  src;
        } op;
        logic [word_w-1:0] data;
    } instr_u;

    // control operators in destination space 0x30 to 0x3f.
    localparam logic [dest_w-1:0] dest_clrf     = 6'h30;
    localparam logic [dest_w-1:0] dest_setf     = 6'h31;
    localparam logic [dest_w-1:0] dest_br       = 6'h38;
    localparam logic [dest_w-1:0] dest_bn       = 6'h39;
    localparam logic [dest_w-1:0] dest_ret_addr = 6'h3e;
    // swaps ipr and the return address.
    localparam logic [dest_w-1:0] dest_return   = 6'h3f;

    // source codes above the register file.
    localparam logic [src_w-1:0] src_ret_addr = 10'h03e;
    // top two source bits that select a small constant.
    localparam logic [1:0]       src_small_const_hi = 2'd2;
    localparam logic [src_w-1:0] src_ad0  = 10'h300;
    localparam logic [src_w-1:0] src_ad1  = 10'h310;
    localparam logic [src_w-1:0] src_and0 = 10'h330;
    localparam logic [src_w-1:0] src_or0  = 10'h334;
    localparam logic [src_w-1:0] src_xor0 = 10'h338;
    localparam logic [src_w-1:0] src_sh1r = 10'h350;
    localparam logic [src_w-1:0] src_sh1l = 10'h351;
    localparam logic [src_w-1:0] src_sh4l = 10'h352;
    localparam logic [src_w-1:0] src_sh4r = 10'h353;
    localparam logic [src_w-1:0] src_neg1 = 10'h360;
    // inline constant, taken from the next code word.
    localparam logic [src_w-1:0] src_imm16 = 10'h3a0;

    // bit positions in the flag vector.
    // bits 8 to 15 always read 1.
    localparam int flag_z0        = 0;
    localparam int flag_z2        = 1;
    // no adder behind this one, reads 0.
    localparam int flag_z4        = 2;
    localparam int flag_and0_zero = 3;
    localparam int flag_carry     = 4;
    localparam int flag_lt        = 5;
    localparam int flag_gt        = 6;
    localparam int flag_eq        = 7;

endpackage

//--- tb_synapse_core.sv
`timescale 1ns/1ps

module tb_synapse_core import synapse_pkg::*; ();

    localparam int num_regs = 8;
    localparam int ipr_w    = 10;

    // sysreset is the clock and sysclk the reset, as the core names them.
    logic                           sysreset;
    logic                           sysclk;
    logic                           code_ready;
    instr_u                         code_in;
    logic [num_regs-1:0][word_w-1:0] r;
    logic [ipr_w-1:0]               code_addr;
    logic [num_regs-1:0]            r_load;
    logic [num_regs-1:0]            r_read;
    logic [word_w-1:0]              r_load_data;

    // code memory and the address of the fetch in flight.
    logic [word_w-1:0] mem [0:1023];
    logic [ipr_w-1:0]  addr_q;
    // register file model.
    logic [word_w-1:0] r_model [num_regs];
    // expected write stream.
    int                exp_idx [$];
    logic [word_w-1:0] exp_data [$];
    // expected read strobes.
    logic [num_regs-1:0] exp_read [$];
    bit                stall_en;
    int                cycles;
    int                cycle_limit;
    int                errors;
    int                loop_addr;

    synapse_core #(
        .num_regs(num_regs),
        .ipr_w(ipr_w)
    ) u_dut (
        .sysreset(sysreset),
        .sysclk(sysclk),
        .code_in(code_in),
        .code_ready(code_ready),
        .r(r),
        .code_addr(code_addr),
        .r_load(r_load),
        .r_read(r_read),
        .r_load_data(r_load_data)
    );

    bind synapse_core synapse_core_checker #(
        .num_regs(num_regs),
        .ipr_w(ipr_w)
    ) u_checker (.*);

    always #10 sysreset = ~sysreset;

    // a new address is taken only when the current fetch completes.
    always @(posedge sysreset) begin
        if (code_ready || sysclk) begin
            addr_q <= code_addr;
        end
    end

    // all inputs change on the falling edge.
    // about a quarter of the cycles stall when stalls are on.
    always @(negedge sysreset) begin
        code_in <= mem[addr_q];
        for (int i = 0; i < num_regs; i++) begin
            r[i] <= r_model[i];
        end
        code_ready <= stall_en ? ($urandom_range(3) != 0) : 1'b1;
    end

    always @(posedge sysreset) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("=== FAIL ===");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    // every load pulse takes the next expected write.
    always @(posedge sysreset) begin
        int act;
        act = 0;
        if (!sysclk && r_load != '0) begin
            for (int i = 0; i < num_regs; i++) begin
                if (r_load[i]) begin
                    act = i;
                end
            end
            r_model[act] <= r_load_data;
            if (exp_idx.size() == 0) begin
                errors++;
                $display("register %0d was written when no write was expected", act);
                $display("=== FAIL ===");
                $fatal(1, "unexpected register write");
            end else begin
                check_write(exp_idx.pop_front(), act, exp_data.pop_front(), r_load_data);
            end
        end
    end

    // every read pulse takes the next expected read strobe.
    always @(posedge sysreset) begin
        if (!sysclk && r_read != '0) begin
            if (exp_read.size() == 0) begin
                errors++;
                $display("read strobe 0x%02h was set when no read was expected", r_read);
                $display("=== FAIL ===");
                $fatal(1, "unexpected register read");
            end else begin
                check_read(exp_read.pop_front(), r_read);
            end
        end
    end

    task automatic check_write(input int exp_i, input int act_i,
                               input logic [word_w-1:0] exp_d, input logic [word_w-1:0] act_d);
        if (exp_i != act_i || exp_d !== act_d) begin
            errors++;
            $display("FAIL r_load index exp 0x%0h got 0x%0h, r_load_data exp 0x%04h got 0x%04h",
                     exp_i, act_i, exp_d, act_d);
            $display("=== FAIL ===");
            $fatal(1, "register write mismatch");
        end
    endtask

    task automatic check_read(input logic [num_regs-1:0] exp_r,
                              input logic [num_regs-1:0] act_r);
        if (exp_r !== act_r) begin
            errors++;
            $display("FAIL r_read exp 0x%02h got 0x%02h", exp_r, act_r);
            $display("=== FAIL ===");
            $fatal(1, "register read strobe mismatch");
        end
    endtask

    task automatic check_addr(input logic [ipr_w-1:0] exp_a, input logic [ipr_w-1:0] act_a);
        if (exp_a !== act_a) begin
            errors++;
            $display("FAIL code_addr exp 0x%03h got 0x%03h", exp_a, act_a);
            $display("=== FAIL ===");
            $fatal(1, "self-loop address mismatch");
        end
    endtask

    // instruction-level model of the core, fills the expected write stream.
    // returns the self-loop address.
    function automatic int interpret_program();
        logic [word_w-1:0] regs [num_regs];
        logic [word_w-1:0] w;
        logic [word_w-1:0] w1;
        logic [word_w-1:0] val;
        logic [word_w-1:0] f;
        logic [word_w:0]   sum;
        logic [dest_w-1:0] dest;
        logic [src_w-1:0]  src;
        logic [ipr_w-1:0]  pc;
        logic [ipr_w-1:0]  ret;
        logic [ipr_w-1:0]  tmp;
        logic              cin;
        logic              taken;
        logic [num_regs-1:0] rd;
        for (int i = 0; i < num_regs; i++) begin
            regs[i] = '0;
        end
        cin = 1'b0;
        pc  = '0;
        ret = '0;
        exp_idx.delete();
        exp_data.delete();
        exp_read.delete();
        // the reset word copies r0 onto itself.
        exp_idx.push_back(0);
        exp_data.push_back('0);
        exp_read.push_back(num_regs'(1));
        repeat (500) begin
            w    = mem[pc];
            w1   = mem[pc + 1];
            dest = w[word_w-1:src_w];
            src  = w[src_w-1:0];
            sum  = regs[0] + regs[1] + cin;
            f = 16'hff00;
            f[flag_z0]        = (regs[0] == 0);
            f[flag_z2]        = (regs[2] == 0);
            f[flag_and0_zero] = ((regs[0] & regs[1]) == 0);
            f[flag_carry]     = sum[word_w];
            f[flag_lt]        = (regs[0] < regs[1]);
            f[flag_gt]        = (regs[0] > regs[1]);
            f[flag_eq]        = (regs[0] == regs[1]);
            rd = '0;
            if (src < num_regs) begin
                val = regs[src];
                rd[src] = 1'b1;
            end else if (src[9:8] == 2'd2) begin
                val = {8'h00, src[7:0]};
            end else begin
                case (src)
                    src_ret_addr: val = {6'h00, ret};
                    src_ad0:      val = sum[word_w-1:0];
                    src_ad1:      val = regs[2] + regs[3];
                    src_and0:     val = regs[0] & regs[1];
                    src_or0:      val = regs[0] | regs[1];
                    src_xor0:     val = regs[0] ^ regs[1];
                    src_sh1r:     val = regs[0] >> 1;
                    src_sh1l:     val = regs[0] << 1;
                    src_sh4l:     val = regs[0] << 4;
                    src_sh4r:     val = regs[0] >> 4;
                    src_neg1:     val = 16'hffff;
                    src_imm16:    val = w1;
                    default:      val = '0;
                endcase
            end
            if (dest == dest_br || dest == dest_bn) begin
                // br on the always-set flag 15 to itself ends the program.
                if (dest == dest_br && src[3:0] == 4'hf && w1[ipr_w-1:0] == pc) begin
                    return int'(pc);
                end
                taken = f[src[3:0]] ^ (dest == dest_bn);
                pc = taken ? w1[ipr_w-1:0] : pc + 2;
            end else if (dest == dest_return) begin
                tmp = ret;
                ret = pc + 2;
                pc  = tmp;
            end else begin
                if (dest < num_regs) begin
                    exp_idx.push_back(int'(dest));
                    exp_data.push_back(val);
                    regs[dest] = val;
                end
                if (dest == dest_ret_addr) begin
                    ret = val[ipr_w-1:0];
                end
                if (dest == dest_setf && val[0]) begin
                    cin = 1'b1;
                end
                if (dest == dest_clrf && val[0]) begin
                    cin = 1'b0;
                end
                pc = pc + ((src == src_imm16) ? 2 : 1);
            end
            // any executed word with a register source pulses that read strobe.
            if (rd != '0) begin
                exp_read.push_back(rd);
            end
        end
        return -1;
    endfunction

    task automatic load_program();
        // copies and constants, alu results and shifts, branches, then a call and return.
        logic [word_w-1:0] prog [0:46] = '{
            16'h0205, 16'h0603, 16'h0ba0, 16'h1234,
            16'h0c01, 16'hc601, 16'h8000, 16'h1300,
            16'h1710, 16'hc201, 16'h1b30, 16'h1f00,
            16'h1334, 16'h1738, 16'h1b50, 16'h1f51,
            16'h1352, 16'h1753, 16'h1b60, 16'he006,
            16'h0016, 16'h1eee, 16'he406, 16'h0015,
            16'he005, 16'h0015, 16'he407, 16'h001c,
            16'he001, 16'h0015, 16'he400, 16'h0020,
            16'h0360, 16'h8000, 16'he004, 16'h0024,
            16'he404, 16'h0015, 16'hfa2c, 16'hfc00,
            16'h1eee, 16'h0c3e, 16'he00f, 16'h002a,
            16'h083e, 16'hfc00, 16'h1eee
        };
        for (int i = 0; i < 47; i++) begin
            mem[i] = prog[i];
        end
    endtask

    task automatic run_program();
        logic [ipr_w-1:0] min_addr;
        @(negedge sysreset);
        sysclk = 1'b1;
        for (int i = 0; i < num_regs; i++) begin
            r_model[i] = '0;
        end
        void'(interpret_program());
        repeat (3) @(negedge sysreset);
        sysclk = 1'b0;
        while (exp_idx.size() != 0 || exp_read.size() != 0) begin
            @(negedge sysreset);
        end
        // the self-loop cycles from its own address upward.
        min_addr = '1;
        repeat (40) begin
            @(negedge sysreset);
            if (code_addr < min_addr) begin
                min_addr = code_addr;
            end
        end
        check_addr(loop_addr[ipr_w-1:0], min_addr);
    endtask

    initial begin
        void'($urandom(35307));
        sysreset    = 1'b0;
        sysclk      = 1'b1;
        code_ready  = 1'b0;
        code_in     = '0;
        r           = '0;
        addr_q      = '0;
        stall_en    = 1'b0;
        errors      = 0;
        cycles      = 0;
        cycle_limit = 1000;
        for (int i = 0; i < num_regs; i++) begin
            r_model[i] = '0;
        end
        // unused code reads as a do-nothing move tagged with its address.
        for (int i = 0; i < 1024; i++) begin
            mem[i] = {6'h20, 10'(i)};
        end
        load_program();
        loop_addr = interpret_program();
        cycle_limit = 2 * (8 * exp_idx.size() + 200);
        for (int pass = 0; pass < 2; pass++) begin
            stall_en = (pass == 1);
            run_program();
        end
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
